// File: core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int xlen = 64;
  localparam int mem_aw = 12;                      // Byte address bits, 4 KiB.
  localparam int mem_words_dflt = (1 << mem_aw) / 8;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // Encoded as funct3.
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } br_op_e;

  typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4} wb_sel_e;

  typedef struct packed {
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       rs1_en;
    logic       rs2_en;
    logic       a_pc;
    logic       b_imm;
    alu_op_e    alu_op;
    logic       word_op;
    logic       br_en;
    br_op_e     br_op;
    logic       jal_en;
    logic       jalr_en;
    logic       load;
    logic       store;
    logic [1:0] mem_size;
    logic       mem_unsigned;
    logic       wb_en;
    wb_sel_e    wb_sel;
    logic       ebreak;
  } dec_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [7:0]      wstrb;
    logic            write;
  } mem_req_t;

  typedef struct packed {
    logic [xlen-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic [xlen-1:0] wdata;
    logic            wen;
  } retire_t;

endpackage

`default_nettype wire

// File: inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import core_pkg::*; (
  input  logic [31:0]     inst,
  output dec_t            dec,
  output logic [xlen-1:0] imm
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic lui_en, auipc_en, jal_en, jalr_en, br_en, load_en, store_en;
  logic opimm_en, opimm32_en, op_en, op32_en;
  logic i_type, s_type, b_type, u_type, j_type, r_type;
  alu_op_e alu_f3;

  assign opcode = inst[6:2];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign lui_en     = (opcode == 5'b01101);
  assign auipc_en   = (opcode == 5'b00101);
  assign jal_en     = (opcode == 5'b11011);
  assign jalr_en    = (opcode == 5'b11001);
  assign br_en      = (opcode == 5'b11000);
  assign load_en    = (opcode == 5'b00000);
  assign store_en   = (opcode == 5'b01000);
  assign opimm_en   = (opcode == 5'b00100);
  assign opimm32_en = (opcode == 5'b00110);
  assign op_en      = (opcode == 5'b01100) && !funct7[0];  // No M extension.
  assign op32_en    = (opcode == 5'b01110) && !funct7[0];

  assign i_type = jalr_en | load_en | opimm_en | opimm32_en;
  assign s_type = store_en;
  assign b_type = br_en;
  assign u_type = lui_en | auipc_en;
  assign j_type = jal_en;
  assign r_type = op_en | op32_en;

  assign imm = i_type ? {{52{inst[31]}}, inst[31:20]} :
               s_type ? {{52{inst[31]}}, inst[31:25], inst[11:7]} :
               b_type ? {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0} :
               u_type ? {{32{inst[31]}}, inst[31:12], 12'h000} :
               j_type ? {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0} :
                        '0;

  // Bit 30 selects sub only for register forms.
  always_comb begin
    case (funct3)
      3'b000:  alu_f3 = (r_type && inst[30]) ? alu_sub : alu_add;
      3'b001:  alu_f3 = alu_sll;
      3'b010:  alu_f3 = alu_slt;
      3'b011:  alu_f3 = alu_sltu;
      3'b100:  alu_f3 = alu_xor;
      3'b101:  alu_f3 = inst[30] ? alu_sra : alu_srl;
      3'b110:  alu_f3 = alu_or;
      default: alu_f3 = alu_and;
    endcase
  end

  always_comb begin
    dec.rd           = inst[11:7];
    dec.rs1          = inst[19:15];
    dec.rs2          = inst[24:20];
    dec.rs1_en       = i_type | r_type | s_type | b_type;
    dec.rs2_en       = r_type | s_type | b_type;
    dec.a_pc         = auipc_en;
    dec.b_imm        = i_type | s_type | u_type;
    dec.alu_op       = lui_en ? alu_pass_b :
                       (opimm_en | opimm32_en | r_type) ? alu_f3 : alu_add;
    dec.word_op      = opimm32_en | op32_en;
    dec.br_en        = br_en;
    dec.br_op        = br_op_e'(funct3);
    dec.jal_en       = jal_en;
    dec.jalr_en      = jalr_en;
    dec.load         = load_en;
    dec.store        = store_en;
    dec.mem_size     = funct3[1:0];
    dec.mem_unsigned = funct3[2];
    dec.wb_en        = u_type | jal_en | i_type | r_type;
    dec.wb_sel       = load_en ? wb_load : (jal_en | jalr_en) ? wb_pc4 : wb_alu;
    dec.ebreak       = (opcode == 5'b11100) && (funct7 == 7'b0) && (inst[24:20] == 5'b00001);
  end

  always_comb begin
    assert ($onehot0({dec.load, dec.store, dec.br_en, dec.jal_en, dec.jalr_en}))
      else $error("decoder raised more than one control class");
  end

endmodule

`default_nettype wire

// File: exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import core_pkg::*; (
  input  dec_t            dec,
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_val,
  input  logic [xlen-1:0] rs2_val,
  output logic [xlen-1:0] alu_res,
  output logic [xlen-1:0] next_pc,
  output logic            taken
);

  logic [xlen-1:0] op_a, op_b, res, sra_d;
  logic [31:0]     sra_w;
  logic [5:0]      shamt;
  logic            eq, lt, ltu, cond;

  assign op_a  = dec.a_pc ? pc : rs1_val;
  assign op_b  = dec.b_imm ? imm : rs2_val;
  assign shamt = dec.word_op ? {1'b0, op_b[4:0]} : op_b[5:0];
  assign sra_d = $signed(op_a) >>> shamt;
  assign sra_w = $signed(op_a[31:0]) >>> shamt[4:0];

  assign eq  = (op_a == op_b);
  assign lt  = ($signed(op_a) < $signed(op_b));
  assign ltu = (op_a < op_b);

  always_comb begin
    case (dec.alu_op)
      alu_sub:    res = op_a - op_b;
      alu_sll:    res = op_a << shamt;
      alu_slt:    res = {63'b0, lt};
      alu_sltu:   res = {63'b0, ltu};
      alu_xor:    res = op_a ^ op_b;
      alu_srl:    res = dec.word_op ? {32'b0, op_a[31:0] >> shamt[4:0]} : op_a >> shamt;
      alu_sra:    res = dec.word_op ? {32'b0, sra_w} : sra_d;
      alu_or:     res = op_a | op_b;
      alu_and:    res = op_a & op_b;
      alu_pass_b: res = op_b;
      default:    res = op_a + op_b;
    endcase
  end

  assign alu_res = dec.word_op ? {{32{res[31]}}, res[31:0]} : res;

  // Branches compare rs1 against rs2 on the same operand path.
  always_comb begin
    case (dec.br_op)
      br_beq:  cond = eq;
      br_bne:  cond = !eq;
      br_blt:  cond = lt;
      br_bge:  cond = !lt;
      br_bltu: cond = ltu;
      br_bgeu: cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  assign taken   = dec.jal_en | dec.jalr_en | (dec.br_en & cond);
  assign next_pc = dec.jalr_en ? {res[xlen-1:1], 1'b0} : pc + imm;  // Jump target.

endmodule

`default_nettype wire

// File: core_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module core_ctrl import core_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            run,
  output logic            fetch_req_valid,
  input  logic            fetch_req_ready,
  output mem_req_t        fetch_req,
  input  logic            fetch_rsp_valid,
  input  mem_rsp_t        fetch_rsp,
  output logic            lsu_start,
  output logic [xlen-1:0] lsu_addr,
  output logic [xlen-1:0] lsu_wdata,
  output logic            lsu_load,
  output logic            lsu_store,
  output logic [1:0]      lsu_size,
  output logic            lsu_unsigned,
  input  logic            lsu_done,
  input  logic [xlen-1:0] lsu_rdata,
  output logic            retire_valid,
  output retire_t         retire,
  output logic            halted
);

  typedef enum logic [1:0] {st_fetch, st_exec, st_mem, st_wb} state_e;

  state_e          state;
  logic            fetch_wait;
  logic [xlen-1:0] pc, pc_plus4;
  logic [31:0]     inst_q;
  logic [xlen-1:0] load_q;
  logic [xlen-1:0] regs [1:31];
  dec_t            dec;
  logic [xlen-1:0] imm, rs1_val, rs2_val, alu_res, next_pc, wb_val;
  logic            taken;
  logic            mem_op;

  inst_decoder u_dec (
    .inst (inst_q),
    .dec  (dec),
    .imm  (imm)
  );

  exec_unit u_exec (
    .dec     (dec),
    .imm     (imm),
    .pc      (pc),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .alu_res (alu_res),
    .next_pc (next_pc),
    .taken   (taken)
  );

  assign pc_plus4 = pc + 64'd4;
  assign mem_op   = dec.load | dec.store;
  assign rs1_val  = (dec.rs1_en && dec.rs1 != 5'd0) ? regs[dec.rs1] : '0;  // x0 reads zero.
  assign rs2_val  = (dec.rs2_en && dec.rs2 != 5'd0) ? regs[dec.rs2] : '0;

  assign fetch_req = '{addr: {pc[xlen-1:3], 3'b000}, wdata: '0, wstrb: '0, write: 1'b0};

  assign lsu_start    = (state == st_exec) && mem_op;
  assign lsu_addr     = alu_res;
  assign lsu_wdata    = rs2_val;
  assign lsu_load     = dec.load;
  assign lsu_store    = dec.store;
  assign lsu_size     = dec.mem_size;
  assign lsu_unsigned = dec.mem_unsigned;

  always_comb begin
    case (dec.wb_sel)
      wb_load: wb_val = load_q;
      wb_pc4:  wb_val = pc_plus4;
      default: wb_val = alu_res;
    endcase
  end

  assign retire_valid = (state == st_wb);
  assign retire = '{pc: pc, rd: dec.rd, wdata: wb_val, wen: dec.wb_en && dec.rd != 5'd0};

  always_ff @(posedge clk) begin
    if (reset) begin
      state           <= st_fetch;
      fetch_req_valid <= 1'b0;
      fetch_wait      <= 1'b0;
      halted          <= 1'b0;
      pc              <= '0;
    end else begin
      case (state)
        st_fetch: begin
          if (fetch_req_valid && fetch_req_ready) begin
            fetch_req_valid <= 1'b0;
            fetch_wait      <= 1'b1;
          end else if (!fetch_req_valid && !fetch_wait && run && !halted) begin
            fetch_req_valid <= 1'b1;
          end
          if (fetch_wait && fetch_rsp_valid) begin
            fetch_wait <= 1'b0;
            state      <= st_exec;
          end
        end
        st_exec: state <= mem_op ? st_mem : st_wb;
        st_mem:  if (lsu_done) state <= st_wb;
        default: begin
          pc    <= taken ? next_pc : pc_plus4;
          state <= st_fetch;
          if (dec.ebreak) halted <= 1'b1;  // Stays set until reset.
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_wait && fetch_rsp_valid) inst_q <= pc[2] ? fetch_rsp.rdata[63:32] :
                                                         fetch_rsp.rdata[31:0];
    if (lsu_done) load_q <= lsu_rdata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (retire_valid && retire.wen) begin
      regs[dec.rd] <= wb_val;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    fetch_req_valid && !fetch_req_ready |=> fetch_req_valid && $stable(fetch_req));

endmodule

`default_nettype wire

// File: load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import core_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            lsu_start,
  input  logic [xlen-1:0] lsu_addr,
  input  logic [xlen-1:0] lsu_wdata,
  input  logic            lsu_load,
  input  logic            lsu_store,
  input  logic [1:0]      lsu_size,
  input  logic            lsu_unsigned,
  output logic            lsu_done,
  output logic [xlen-1:0] lsu_rdata,
  output logic            mem_req_valid,
  input  logic            mem_req_ready,
  output mem_req_t        mem_req,
  input  logic            mem_rsp_valid,
  input  mem_rsp_t        mem_rsp
);

  logic            busy;
  logic [2:0]      off, off_q;
  logic [1:0]      size_q;
  logic            uns_q;
  logic [7:0]      strb;
  logic [xlen-1:0] lane;

  assign off = lsu_addr[2:0];

  always_comb begin
    case (lsu_size)
      2'd0:    strb = 8'h01 << off;
      2'd1:    strb = 8'h03 << off;
      2'd2:    strb = 8'h0f << off;
      default: strb = 8'hff;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_req_valid <= 1'b0;
      busy          <= 1'b0;
    end else begin
      if (lsu_start) begin
        mem_req_valid <= 1'b1;
        busy          <= 1'b1;
      end else if (mem_req_valid && mem_req_ready) begin
        mem_req_valid <= 1'b0;
      end
      if (busy && mem_rsp_valid) busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_start) begin
      mem_req.addr  <= {lsu_addr[xlen-1:3], 3'b000};
      mem_req.wdata <= lsu_wdata << {off, 3'b000};  // Into its byte lane.
      mem_req.wstrb <= lsu_store ? strb : 8'h00;
      mem_req.write <= lsu_store;
      off_q         <= off;
      size_q        <= lsu_size;
      uns_q         <= lsu_unsigned;
    end
  end

  assign lane = mem_rsp.rdata >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      2'd0:    lsu_rdata = uns_q ? {56'b0, lane[7:0]} : {{56{lane[7]}}, lane[7:0]};
      2'd1:    lsu_rdata = uns_q ? {48'b0, lane[15:0]} : {{48{lane[15]}}, lane[15:0]};
      2'd2:    lsu_rdata = uns_q ? {32'b0, lane[31:0]} : {{32{lane[31]}}, lane[31:0]};
      default: lsu_rdata = lane;
    endcase
  end

  assign lsu_done = busy && mem_rsp_valid;

  // Core must issue exactly one kind of access, naturally aligned.
  assert property (@(posedge clk) disable iff (reset)
    lsu_start |-> (lsu_load ^ lsu_store) && ((off & ~(3'b111 << lsu_size)) == 3'b000));

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import core_pkg::*; #(
  parameter int mem_words = mem_words_dflt
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     host_req_valid,
  output logic     host_req_ready,
  input  mem_req_t host_req,
  output logic     host_rsp_valid,
  output mem_rsp_t host_rsp,
  input  logic     data_req_valid,
  output logic     data_req_ready,
  input  mem_req_t data_req,
  output logic     data_rsp_valid,
  output mem_rsp_t data_rsp,
  input  logic     fetch_req_valid,
  output logic     fetch_req_ready,
  input  mem_req_t fetch_req,
  output logic     fetch_rsp_valid,
  output mem_rsp_t fetch_rsp,
  output logic     mem_req_valid,
  input  logic     mem_req_ready,
  output mem_req_t mem_req,
  input  logic     mem_rsp_valid,
  input  mem_rsp_t mem_rsp
);

  logic [2:0] req, gnt, rdy, owner_q;  // Bit 0 host, 1 data, 2 fetch.
  logic       pending, range_ok, range_ok_q;
  mem_req_t   sel;
  mem_rsp_t   rsp;

  assign req = {fetch_req_valid, data_req_valid, host_req_valid};
  assign gnt = pending ? 3'b000 : req & (~req + 3'd1);  // Lowest set bit wins.
  assign rdy = gnt & {3{mem_req_ready}};
  assign {fetch_req_ready, data_req_ready, host_req_ready} = rdy;

  always_comb begin
    case (gnt)
      3'b001:  sel = host_req;
      3'b010:  sel = data_req;
      default: sel = fetch_req;
    endcase
  end

  // Out-of-range accesses write nothing and read zero.
  assign range_ok = sel.addr[xlen-1:3] < (xlen-3)'(mem_words);

  always_comb begin
    mem_req = sel;
    if (!range_ok) begin
      mem_req.wstrb = '0;
      mem_req.write = 1'b0;
    end
  end

  assign mem_req_valid = |gnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
      owner_q <= 3'b000;
    end else begin
      pending <= |rdy;
      if (|rdy) owner_q <= gnt;
    end
  end

  always_ff @(posedge clk) begin
    if (|rdy) range_ok_q <= range_ok;
  end

  assign rsp.rdata = range_ok_q ? mem_rsp.rdata : '0;

  assign host_rsp_valid  = mem_rsp_valid & owner_q[0];
  assign data_rsp_valid  = mem_rsp_valid & owner_q[1];
  assign fetch_rsp_valid = mem_rsp_valid & owner_q[2];
  assign host_rsp  = rsp;
  assign data_rsp  = rsp;
  assign fetch_rsp = rsp;

  assert property (@(posedge clk) disable iff (reset)
    |rdy |-> $onehot0(rdy) ##1 rdy == 3'b000);

endmodule

`default_nettype wire

// File: unified_mem.sv
`timescale 1ns/1ps
`default_nettype none

module unified_mem import core_pkg::*; #(
  parameter int mem_words = mem_words_dflt
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_valid,
  output logic     req_ready,
  input  mem_req_t req,
  output logic     rsp_valid,
  output mem_rsp_t rsp
);

  localparam int aw = $clog2(mem_words);

  logic [xlen-1:0] ram [mem_words];
  logic [aw-1:0]   idx;

  assign req_ready = 1'b1;
  assign idx = req.addr[aw+2:3];

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      rsp.rdata <= ram[idx];  // Old data on a write.
      if (req.write) begin
        for (int b = 0; b < 8; b++) begin
          if (req.wstrb[b]) ram[idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) rsp_valid <= 1'b0;
    else       rsp_valid <= req_valid && req_ready;
  end

endmodule

`default_nettype wire

// File: rv_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_top import core_pkg::*; #(
  parameter int mem_words = mem_words_dflt
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     run,
  input  logic     host_req_valid,
  output logic     host_req_ready,
  input  mem_req_t host_req,
  output logic     host_rsp_valid,
  output mem_rsp_t host_rsp,
  output logic     retire_valid,
  output retire_t  retire,
  output logic     halted
);

  logic            fetch_req_valid, fetch_req_ready, fetch_rsp_valid;
  mem_req_t        fetch_req;
  mem_rsp_t        fetch_rsp;
  logic            data_req_valid, data_req_ready, data_rsp_valid;
  mem_req_t        data_req;
  mem_rsp_t        data_rsp;
  logic            mem_req_valid, mem_req_ready, mem_rsp_valid;
  mem_req_t        mem_req;
  mem_rsp_t        mem_rsp;
  logic            lsu_start, lsu_load, lsu_store, lsu_unsigned, lsu_done;
  logic [1:0]      lsu_size;
  logic [xlen-1:0] lsu_addr, lsu_wdata, lsu_rdata;

  core_ctrl u_core (
    .clk             (clk),
    .reset           (reset),
    .run             (run),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req_ready (fetch_req_ready),
    .fetch_req       (fetch_req),
    .fetch_rsp_valid (fetch_rsp_valid),
    .fetch_rsp       (fetch_rsp),
    .lsu_start       (lsu_start),
    .lsu_addr        (lsu_addr),
    .lsu_wdata       (lsu_wdata),
    .lsu_load        (lsu_load),
    .lsu_store       (lsu_store),
    .lsu_size        (lsu_size),
    .lsu_unsigned    (lsu_unsigned),
    .lsu_done        (lsu_done),
    .lsu_rdata       (lsu_rdata),
    .retire_valid    (retire_valid),
    .retire          (retire),
    .halted          (halted)
  );

  load_store_unit u_lsu (
    .clk           (clk),
    .reset         (reset),
    .lsu_start     (lsu_start),
    .lsu_addr      (lsu_addr),
    .lsu_wdata     (lsu_wdata),
    .lsu_load      (lsu_load),
    .lsu_store     (lsu_store),
    .lsu_size      (lsu_size),
    .lsu_unsigned  (lsu_unsigned),
    .lsu_done      (lsu_done),
    .lsu_rdata     (lsu_rdata),
    .mem_req_valid (data_req_valid),
    .mem_req_ready (data_req_ready),
    .mem_req       (data_req),
    .mem_rsp_valid (data_rsp_valid),
    .mem_rsp       (data_rsp)
  );

  mem_arbiter #(.mem_words(mem_words)) u_arb (
    .clk             (clk),
    .reset           (reset),
    .host_req_valid  (host_req_valid),
    .host_req_ready  (host_req_ready),
    .host_req        (host_req),
    .host_rsp_valid  (host_rsp_valid),
    .host_rsp        (host_rsp),
    .data_req_valid  (data_req_valid),
    .data_req_ready  (data_req_ready),
    .data_req        (data_req),
    .data_rsp_valid  (data_rsp_valid),
    .data_rsp        (data_rsp),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req_ready (fetch_req_ready),
    .fetch_req       (fetch_req),
    .fetch_rsp_valid (fetch_rsp_valid),
    .fetch_rsp       (fetch_rsp),
    .mem_req_valid   (mem_req_valid),
    .mem_req_ready   (mem_req_ready),
    .mem_req         (mem_req),
    .mem_rsp_valid   (mem_rsp_valid),
    .mem_rsp         (mem_rsp)
  );

  unified_mem #(.mem_words(mem_words)) u_mem (
    .clk       (clk),
    .reset     (reset),
    .req_valid (mem_req_valid),
    .req_ready (mem_req_ready),
    .req       (mem_req),
    .rsp_valid (mem_rsp_valid),
    .rsp       (mem_rsp)
  );

endmodule

`default_nettype wire

// File: tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [63:0] m_regs [32];
logic [63:0] m_mem [mem_words];
logic [63:0] m_pc;
bit          m_halted;
int          m_steps;

function automatic logic [63:0] sext32(input logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

function automatic logic [63:0] alu_calc(input logic [2:0] f3, input logic alt,
                                         input logic word, input logic [63:0] a,
                                         input logic [63:0] b);
  logic [63:0] r;
  int          sh;
  sh = word ? int'(b[4:0]) : int'(b[5:0]);
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << sh;
    3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    3'd3: r = (a < b) ? 64'd1 : 64'd0;
    3'd4: r = a ^ b;
    3'd5: begin
      if (word) r = {32'h0, alt ? 32'($signed(a[31:0]) >>> sh) : a[31:0] >> sh};
      else      r = alt ? 64'($signed(a) >>> sh) : a >> sh;
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return word ? sext32(r[31:0]) : r;
endfunction

function automatic bit branch_taken(input logic [2:0] f3, input logic [63:0] a,
                                    input logic [63:0] b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    default: return a >= b;
  endcase
endfunction

// Copies the loaded image and clears the architectural state.
task automatic model_load();
  for (int i = 0; i < 32; i++) m_regs[i] = '0;
  for (int i = 0; i < mem_words; i++) m_mem[i] = img[i];
  m_pc = '0;
  m_halted = 0;
  m_steps = 0;
endtask

task automatic model_step(output retire_t exp);
  logic [31:0] in;
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic [63:0] a, b, ii, si, res, npc, addr, lane;
  logic        wen;
  in   = m_pc[2] ? m_mem[m_pc[11:3]][63:32] : m_mem[m_pc[11:3]][31:0];
  f3   = in[14:12];
  rd   = in[11:7];
  a    = m_regs[in[19:15]];
  b    = m_regs[in[24:20]];
  ii   = {{52{in[31]}}, in[31:20]};
  si   = {{52{in[31]}}, in[31:25], in[11:7]};
  res  = '0;
  wen  = 1'b0;
  npc  = m_pc + 64'd4;
  case (in[6:0])
    7'h37: begin res = {{32{in[31]}}, in[31:12], 12'h0}; wen = 1'b1; end
    7'h17: begin res = m_pc + {{32{in[31]}}, in[31:12], 12'h0}; wen = 1'b1; end
    7'h6f: begin
      res = m_pc + 64'd4;
      wen = 1'b1;
      npc = m_pc + {{44{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
    end
    7'h67: begin res = m_pc + 64'd4; wen = 1'b1; npc = (a + ii) & ~64'd1; end
    7'h63: if (branch_taken(f3, a, b))
      npc = m_pc + {{52{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
    7'h03: begin
      addr = a + ii;
      lane = m_mem[addr[11:3]] >> (8 * int'(addr[2:0]));
      case (f3)
        3'd0: res = {{56{lane[7]}}, lane[7:0]};
        3'd1: res = {{48{lane[15]}}, lane[15:0]};
        3'd2: res = sext32(lane[31:0]);
        3'd4: res = {56'h0, lane[7:0]};
        3'd5: res = {48'h0, lane[15:0]};
        3'd6: res = {32'h0, lane[31:0]};
        default: res = lane;
      endcase
      wen = 1'b1;
    end
    7'h23: begin
      addr = a + si;
      for (int k = 0; k < (1 << f3[1:0]); k++)
        m_mem[addr[11:3]][8 * (int'(addr[2:0]) + k) +: 8] = b[8 * k +: 8];
    end
    7'h13: begin res = alu_calc(f3, in[30] && f3 == 3'd5, 1'b0, a, ii); wen = 1'b1; end
    7'h1b: begin res = alu_calc(f3, in[30] && f3 == 3'd5, 1'b1, a, ii); wen = 1'b1; end
    7'h33: begin res = alu_calc(f3, in[30], 1'b0, a, b); wen = 1'b1; end
    7'h3b: begin res = alu_calc(f3, in[30], 1'b1, a, b); wen = 1'b1; end
    default: if (in == 32'h0010_0073) m_halted = 1;
  endcase
  if (wen && rd != 5'd0) m_regs[rd] = res;
  exp = '{pc: m_pc, rd: rd, wdata: res, wen: wen && rd != 5'd0};
  m_pc = npc;
  m_steps++;
endtask

`endif

// File: tb_rv_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_top import core_pkg::*;;

  localparam int mem_words = 512;

  logic     clk, reset, run;
  logic     host_req_valid, host_req_ready, host_rsp_valid;
  mem_req_t host_req;
  mem_rsp_t host_rsp;
  logic     retire_valid, halted;
  retire_t  retire;

  logic [31:0] seed;
  logic [63:0] img [mem_words];
  logic [31:0] prog [$];
  int          retire_count;

  `include "tb_ref_model.svh"

  rv_top #(.mem_words(mem_words)) uut (
    .clk            (clk),
    .reset          (reset),
    .run            (run),
    .host_req_valid (host_req_valid),
    .host_req_ready (host_req_ready),
    .host_req       (host_req),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp       (host_rsp),
    .retire_valid   (retire_valid),
    .retire         (retire),
    .halted         (halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // One host transfer; the response must follow the accepting edge by one cycle.
  task automatic host_access(input logic [63:0] addr, input logic [63:0] wdata,
                             input logic write, output logic [63:0] rdata);
    int t;
    @(negedge clk);
    host_req_valid = 1'b1;
    host_req = '{addr: addr, wdata: wdata, wstrb: write ? 8'hff : 8'h00, write: write};
    #1;
    t = 0;
    while (!host_req_ready) begin
      t++;
      if (t > 100) abort_run("Host request was never accepted by the arbiter");
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    host_req_valid = 1'b0;
    assert (host_rsp_valid === 1'b1)
      else abort_run("Host response did not arrive one cycle after the transfer");
    rdata = host_rsp.rdata;
  endtask

  task automatic gen_program();
    logic [31:0] r, q;
    logic [4:0]  rd, ra, rs1, rs2;
    logic [2:0]  f3, off;
    logic [11:0] imm;
    logic [63:0] addr;
    prog.delete();
    prog.push_back({20'd1, 5'd31, 7'h37});  // x31 = 0x1000, data base.
    while (prog.size() < 58) begin
      r   = next_rand();
      q   = next_rand();
      rd  = 5'(r[7:0] % 31);
      ra  = 5'(1 + q[20:16] % 30);
      rs1 = r[12:8];
      rs2 = r[17:13];
      f3  = r[20:18];
      off = (q[13:11] >> q[1:0]) << q[1:0];
      addr = 64'h800 + {53'h0, q[10:3], off};
      case (r[31:29])
        3'd0: prog.push_back({((f3 == 3'd0 || f3 == 3'd5) && q[0]) ? 7'h20 : 7'h00,
                              rs2, rs1, f3, rd, 7'h33});
        3'd1: begin
          imm = q[11:0];
          if (f3 == 3'd1) imm = {6'h0, q[5:0]};
          if (f3 == 3'd5) imm = {1'b0, q[6], 4'h0, q[5:0]};
          prog.push_back({imm, rs1, f3, rd, 7'h13});
        end
        3'd2: begin
          f3 = (q[13:12] == 2'd0) ? 3'd1 : (q[13:12] == 2'd1) ? 3'd5 : 3'd0;
          if (q[14])
            prog.push_back({(f3 != 3'd1 && q[0]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h3b});
          else if (f3 == 3'd0)
            prog.push_back({q[31:20], rs1, f3, rd, 7'h1b});
          else
            prog.push_back({1'b0, f3 == 3'd5 && q[6], 5'h0, q[4:0], rs1, f3, rd, 7'h1b});
        end
        3'd3: prog.push_back({q[19:0], rd, 7'h37});
        3'd4: prog.push_back({addr[11:0], 5'd31, q[2:0] == 3'd7 ? 3'd3 : q[2:0], rd, 7'h03});
        3'd5: prog.push_back({addr[11:5], rs2, 5'd31, 1'b0, q[1:0], addr[4:0], 7'h23});
        3'd6: begin
          f3 = (q[2:0] == 3'd2 || q[2:0] == 3'd3) ? q[2:0] + 3'd2 : q[2:0];
          prog.push_back({7'h0, rs2, rs1, f3, 4'b0100, 1'b0, 7'h63});  // Skips one.
          prog.push_back({q[31:20], rs1, 3'd0, rd, 7'h13});
        end
        default: begin
          if (q[0]) begin
            prog.push_back({1'b0, 10'd4, 1'b0, 8'h0, rd, 7'h6f});
          end else begin
            prog.push_back({20'h0, ra, 7'h17});
            prog.push_back({12'd12, ra, 3'd0, rd, 7'h67});
          end
          prog.push_back({q[31:20], rs1, 3'd0, rd, 7'h13});
        end
      endcase
    end
    prog.push_back(32'h0010_0073);
  endtask

  always @(negedge clk) begin
    retire_t exp;
    if (!reset && retire_valid) begin
      if (m_halted) abort_run("An instruction retired after EBREAK");
      model_step(exp);
      check_value("retire pc", retire.pc, exp.pc);
      check_value("retire wen", 64'(retire.wen), 64'(exp.wen));
      if (exp.wen) begin
        check_value("retire rd", 64'(retire.rd), 64'(exp.rd));
        check_value("retire wdata", retire.wdata, exp.wdata);
      end
      retire_count++;
    end
  end

  initial begin
    logic [63:0] got;
    retire_t     step_exp;
    int          t, idx, at_halt, exp_steps;
    seed = 32'he352_27d4;
    reset = 1'b1;
    run = 1'b0;
    host_req_valid = 1'b0;
    host_req = '0;
    retire_count = 0;
    m_halted = 0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    repeat (20) @(negedge clk);
    check_value("retires with run low", 64'(retire_count), 64'd0);

    gen_program();
    for (int i = 0; i < mem_words; i++) img[i] = {next_rand(), next_rand()};
    for (int k = 0; k < prog.size(); k++) img[k >> 1][32 * (k & 1) +: 32] = prog[k];
    for (int i = 0; i < mem_words; i++) host_access(64'(i * 8), img[i], 1'b1, got);

    // Dry run of the model to learn how many instructions reach EBREAK.
    model_load();
    t = 0;
    while (!m_halted) begin
      model_step(step_exp);
      t++;
      if (t > 1000) abort_run("Reference model did not reach EBREAK");
    end
    exp_steps = m_steps;
    model_load();

    for (int n = 0; n < 16; n++) begin
      idx = int'(next_rand() % mem_words);
      host_access(64'(idx * 8), '0, 1'b0, got);
      check_value("host readback", got, img[idx]);
    end

    @(negedge clk);
    run = 1'b1;
    fork
      begin
        t = 0;
        while (!halted) begin
          t++;
          if (t > 20000) abort_run("Core did not halt at EBREAK in time");
          @(negedge clk);
        end
      end
      begin
        // Program words never change, so reads under load test only arbitration.
        for (int n = 0; n < 20; n++) begin
          idx = int'(next_rand() % ((prog.size() + 1) / 2));
          host_access(64'(idx * 8), '0, 1'b0, got);
          check_value("host read while running", got, img[idx]);
        end
      end
    join
    at_halt = retire_count;
    repeat (50) @(negedge clk);
    check_value("retires after halt", 64'(retire_count), 64'(at_halt));
    check_value("retire count", 64'(retire_count), 64'(exp_steps));
    if (!m_halted) abort_run("Model did not reach EBREAK with the core");
    for (int i = mem_words / 2; i < mem_words; i++) begin
      host_access(64'(i * 8), '0, 1'b0, got);
      check_value("data region", got, m_mem[i]);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
core_pkg.sv
inst_decoder.sv
exec_unit.sv
core_ctrl.sv
load_store_unit.sv
mem_arbiter.sv
unified_mem.sv
rv_top.sv
tb_rv_top.sv

// File: Makefile
TOP := tb_rv_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
